// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module vmem_unit_tb -o vmem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/vmem_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
else
    echo "Pass message not found in simulator output"
    exit 1
fi

// ==== src.f ====
vmem_pkg.sv
vmem_lsc_if.sv
vmem_ram_if.sv
vmem_serializer.sv
vmem_lsc.sv
vmem_data_ram.sv
vmem_load_collect.sv
vmem_unit.sv
vmem_unit_sva.sv
vmem_unit_tb.sv

// ==== vmem_data_ram.sv ====
// Word-addressed data RAM with per-byte write enables
// Read data is registered and follows the address by one cycle

`timescale 1ns/100ps

module vmem_data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic       CLK,
    vmem_ram_if.ram    ram
);

    vmem_pkg::word_t mem [RAM_WORDS];

    always_ff @(posedge CLK) begin
        if (ram.we) begin
            for (int b = 0; b < 4; b++) begin
                if (ram.be[b]) begin
                    mem[ram.word_addr][b*8 +: 8] <= ram.wdata[b*8 +: 8];
                end
            end
        end
        ram.rdata <= mem[ram.word_addr];  // Old data on a same-cycle write
    end

endmodule

// ==== vmem_load_collect.sv ====
// Lane result registers for vector loads
// Each returned element is written to the register of its lane

`timescale 1ns/100ps

module vmem_load_collect (
    input  logic            CLK,
    input  logic            nRST,
    vmem_lsc_if.collect     lsc,
    output vmem_pkg::word_t vlane_load_data [vmem_pkg::NUM_LANES]
);

    // Masked lanes see no load_valid and keep their value
    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            for (int i = 0; i < vmem_pkg::NUM_LANES; i++) begin
                vlane_load_data[i] <= '0;
            end
        end else if (lsc.load_valid) begin
            vlane_load_data[lsc.lane] <= lsc.load_data;
        end
    end

endmodule

// ==== vmem_lsc.sv ====
// Load/store controller for single lane accesses
// Waits MEM_LATENCY cycles per request, then pulses ready. Loads need
// MEM_LATENCY of 2 or more so the registered RAM read is back in time

`timescale 1ns/100ps

module vmem_lsc #(
    parameter int MEM_LATENCY = 2,
    parameter int RAM_WORDS   = 256
) (
    input  logic       CLK,
    input  logic       nRST,
    vmem_lsc_if.lsc    lsc,
    vmem_ram_if.ctrl   ram
);

    localparam int ADDR_BITS = $clog2(RAM_WORDS);
    localparam int CNT_BITS  = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
    localparam logic [CNT_BITS-1:0] LAST_CNT = CNT_BITS'(MEM_LATENCY - 1);

    logic [CNT_BITS-1:0] cnt;
    logic                req;
    logic                ready;
    logic [4:0]          shamt;      // Byte offset in bits
    vmem_pkg::word_t     rd_shifted;

    assign req   = lsc.ren | lsc.wen;
    assign ready = req & (cnt == LAST_CNT);
    assign shamt = {lsc.addr[1:0], 3'b000};

    // Latency counter, restarts for every request
    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            cnt <= '0;
        end else if (req && !ready) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    assign lsc.ready      = ready;
    assign lsc.load_valid = lsc.ren & ready;

    // Store path, the write lands in the ready cycle
    assign ram.word_addr = lsc.addr[ADDR_BITS+1:2];
    assign ram.wdata     = lsc.store_data << shamt;  // Byte enables drop the excess
    assign ram.we        = lsc.wen & ready;

    always_comb begin
        case (lsc.load_type)
            vmem_pkg::LB: ram.be = 4'b0001 << lsc.addr[1:0];
            vmem_pkg::LH: ram.be = 4'b0011 << {lsc.addr[1], 1'b0};
            default:      ram.be = 4'b1111;
        endcase
    end

    // Load path, shift the element down and zero extend
    assign rd_shifted = ram.rdata >> shamt;

    always_comb begin
        case (lsc.load_type)
            vmem_pkg::LB: lsc.load_data = {24'b0, rd_shifted[7:0]};
            vmem_pkg::LH: lsc.load_data = {16'b0, rd_shifted[15:0]};
            default:      lsc.load_data = rd_shifted;
        endcase
    end

endmodule

// ==== vmem_lsc_if.sv ====
// One scalar lane access between the serializer, the load/store controller
// and the load collector. Strobes are held until a one-cycle ready pulse

`timescale 1ns/100ps

interface vmem_lsc_if;

    // Request side, driven by the serializer
    logic                   ren;
    logic                   wen;
    vmem_pkg::word_t        addr;
    vmem_pkg::word_t        store_data;
    vmem_pkg::load_type_t   load_type;
    vmem_pkg::lane_t        lane;

    // Response side, driven by the controller
    logic                   ready;
    vmem_pkg::word_t        load_data;
    logic                   load_valid;  // Pulses with ready on loads

    modport serial (
        output ren, wen, addr, store_data, load_type, lane,
        input  ready
    );

    modport lsc (
        input  ren, wen, addr, store_data, load_type,
        output ready, load_data, load_valid
    );

    modport collect (
        input lane, load_data, load_valid
    );

endinterface

// ==== vmem_pkg.sv ====
// Shared types and constants for the vector memory access unit
// Referenced by scoped name from the interfaces and RTL modules

package vmem_pkg;

    // Lanes per vector memory micro-op
    localparam int NUM_LANES = 4;

    // Data and address word of the scalar core
    typedef logic [31:0] word_t;

    // Index of the lane being accessed
    typedef logic [$clog2(NUM_LANES)-1:0] lane_t;

    // Element width of the vector access
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    // Width of one scalar access, loads are zero extended
    typedef enum logic [1:0] {
        LB = 2'd0,
        LH = 2'd1,
        LW = 2'd2
    } load_type_t;

endpackage

// ==== vmem_ram_if.sv ====
// Word-wide port between the load/store controller and the data RAM

`timescale 1ns/100ps

interface vmem_ram_if #(
    parameter int RAM_WORDS = 256
);

    logic [$clog2(RAM_WORDS)-1:0] word_addr;
    vmem_pkg::word_t              wdata;
    logic [3:0]                   be;     // One enable per byte lane
    logic                         we;
    vmem_pkg::word_t              rdata;  // Registered, one cycle after word_addr

    modport ctrl (
        output word_addr, wdata, be, we,
        input  rdata
    );

    modport ram (
        input  word_addr, wdata, be, we,
        output rdata
    );

endinterface

// ==== vmem_serializer.sv ====
// Splits one vector memory micro-op into single lane accesses
// Walks lanes 0 to 3, skipping masked lanes in one cycle each

`timescale 1ns/100ps

module vmem_serializer #(
    parameter int UOP_BITS = 2
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  vindexed,
    input  vmem_pkg::sew_t        veew,
    input  logic [UOP_BITS-1:0]   vuop_num,
    input  vmem_pkg::word_t       base,
    input  vmem_pkg::word_t       stride,
    input  vmem_pkg::word_t       vlane_addr [vmem_pkg::NUM_LANES],
    input  logic [vmem_pkg::NUM_LANES-1:0] vlane_mask,
    input  vmem_pkg::word_t       vlane_store_data [vmem_pkg::NUM_LANES],
    input  logic                  vmemren,
    input  logic                  vmemwen,
    vmem_lsc_if.serial            lsc,
    output logic                  stall
);

    typedef enum logic [1:0] { VL0, VL1, VL2, VL3 } lane_state_t;

    lane_state_t          state, next_state;
    vmem_pkg::word_t      run_addr, next_run_addr;
    vmem_pkg::word_t      stride_addr;
    vmem_pkg::lane_t      cur_lane;
    vmem_pkg::load_type_t load_type;
    logic                 req;
    logic                 lane_active;
    logic                 advance;

    assign cur_lane    = vmem_pkg::lane_t'(state);
    assign req         = vmemren | vmemwen;
    assign lane_active = vlane_mask[cur_lane];
    assign advance     = req & (lsc.ready | ~lane_active);  // Masked lane moves on at once

    // First lane of a new instruction starts from the base
    assign stride_addr = (state == VL0 && vuop_num == '0) ? base : run_addr;

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            state    <= VL0;
            run_addr <= '0;
        end else begin
            state    <= next_state;
            run_addr <= next_run_addr;
        end
    end

    always_comb begin
        next_state    = VL0;
        next_run_addr = run_addr;
        stall         = 1'b0;
        if (req) begin
            stall      = 1'b1;
            next_state = state;
            if (advance) begin
                next_run_addr = stride_addr + stride;
                next_state    = lane_state_t'(state + 2'd1);  // VL3 wraps to VL0
                if (state == VL3) begin
                    stall = 1'b0;                             // Micro-op done this cycle
                end
            end
        end
    end

    // Element width to scalar access width
    always_comb begin
        case (veew)
            vmem_pkg::SEW8:  load_type = vmem_pkg::LB;
            vmem_pkg::SEW16: load_type = vmem_pkg::LH;
            default:         load_type = vmem_pkg::LW;
        endcase
    end

    assign lsc.ren        = vmemren & lane_active;
    assign lsc.wen        = vmemwen & lane_active;
    assign lsc.addr       = vindexed ? vlane_addr[cur_lane] : stride_addr;
    assign lsc.store_data = vlane_store_data[cur_lane];
    assign lsc.load_type  = load_type;
    assign lsc.lane       = cur_lane;

endmodule

// ==== vmem_unit.sv ====
// Top level of the vector memory access unit
// Serializer, load/store controller, data RAM and load collector

`timescale 1ns/100ps

module vmem_unit #(
    parameter int MEM_LATENCY = 2,
    parameter int RAM_WORDS   = 256,
    parameter int UOP_BITS    = 2
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  vmemren,
    input  logic                  vmemwen,
    input  logic                  vindexed,
    input  vmem_pkg::sew_t        veew,
    input  logic [UOP_BITS-1:0]   vuop_num,
    input  vmem_pkg::word_t       base,
    input  vmem_pkg::word_t       stride,
    input  vmem_pkg::word_t       vlane_addr [vmem_pkg::NUM_LANES],
    input  logic [vmem_pkg::NUM_LANES-1:0] vlane_mask,
    input  vmem_pkg::word_t       vlane_store_data [vmem_pkg::NUM_LANES],
    output vmem_pkg::word_t       vlane_load_data [vmem_pkg::NUM_LANES],
    output logic                  stall
);

    vmem_lsc_if                          lsc_bus ();
    vmem_ram_if #(.RAM_WORDS(RAM_WORDS)) ram_bus ();

    vmem_serializer #(.UOP_BITS(UOP_BITS)) u_serializer (
        .CLK              (CLK),
        .nRST             (nRST),
        .vindexed         (vindexed),
        .veew             (veew),
        .vuop_num         (vuop_num),
        .base             (base),
        .stride           (stride),
        .vlane_addr       (vlane_addr),
        .vlane_mask       (vlane_mask),
        .vlane_store_data (vlane_store_data),
        .vmemren          (vmemren),
        .vmemwen          (vmemwen),
        .lsc              (lsc_bus.serial),
        .stall            (stall)
    );

    vmem_lsc #(
        .MEM_LATENCY (MEM_LATENCY),
        .RAM_WORDS   (RAM_WORDS)
    ) u_lsc (
        .CLK  (CLK),
        .nRST (nRST),
        .lsc  (lsc_bus.lsc),
        .ram  (ram_bus.ctrl)
    );

    vmem_data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
        .CLK (CLK),
        .ram (ram_bus.ram)
    );

    vmem_load_collect u_load_collect (
        .CLK             (CLK),
        .nRST            (nRST),
        .lsc             (lsc_bus.collect),
        .vlane_load_data (vlane_load_data)
    );

endmodule

// ==== vmem_unit_sva.sv ====
// Handshake assertions for the lane serializer
// Bound into vmem_serializer from the testbench

`timescale 1ns/100ps

module vmem_unit_sva (
    input logic                           CLK,
    input logic                           nRST,
    input logic                           vmemren,
    input logic                           vmemwen,
    input logic                           ren,
    input logic                           wen,
    input logic                           ready,
    input logic                           stall,
    input vmem_pkg::word_t                addr,
    input logic [vmem_pkg::NUM_LANES-1:0] mask
);

    logic            strobe;
    logic            req;
    vmem_pkg::lane_t walk_lane;  // Lane position seen from the handshake

    assign strobe = ren | wen;
    assign req    = vmemren | vmemwen;

    // An active lane ends on ready, a masked lane after one quiet cycle
    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            walk_lane <= '0;
        end else if (!req) begin
            walk_lane <= '0;
        end else if (ready || !strobe) begin
            walk_lane <= walk_lane + 1'b1;
        end
    end

    // Held request keeps its address and strobes until ready
    a_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
        strobe && !ready |=> $stable(addr) && $stable(ren) && $stable(wen))
        else $error("lane request changed before ready");

    a_mask_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        strobe |-> mask[walk_lane])
        else $error("strobe raised for a masked lane");

    a_stall_req: assert property (@(posedge CLK) disable iff (!nRST)
        stall |-> (vmemren || vmemwen))
        else $error("stall high with no vector memory request");

endmodule

// ==== vmem_unit_tb.sv ====
// Testbench for the vector memory access unit
// Runs a table of micro-ops and checks lane results against a byte-wide shadow memory

`timescale 1ns/100ps

module vmem_unit_tb;

    localparam int MEM_LATENCY = 2;
    localparam int RAM_WORDS   = 256;
    localparam int MAX_OPS     = 20;
    localparam int WAIT_LIMIT  = 100;  // Cycles per micro-op before giving up

    logic                  CLK;
    logic                  nRST;
    logic                  vmemren;
    logic                  vmemwen;
    logic                  vindexed;
    vmem_pkg::sew_t        veew;
    logic [1:0]            vuop_num;
    vmem_pkg::word_t       base;
    vmem_pkg::word_t       stride;
    vmem_pkg::word_t       vlane_addr [vmem_pkg::NUM_LANES];
    logic [3:0]            vlane_mask;
    vmem_pkg::word_t       vlane_store_data [vmem_pkg::NUM_LANES];
    vmem_pkg::word_t       vlane_load_data [vmem_pkg::NUM_LANES];
    logic                  stall;

    // Micro-op table, one entry per index
    logic                  op_store   [MAX_OPS];
    logic                  op_indexed [MAX_OPS];
    vmem_pkg::sew_t        op_eew     [MAX_OPS];
    logic [1:0]            op_uop     [MAX_OPS];
    vmem_pkg::word_t       op_base    [MAX_OPS];
    vmem_pkg::word_t       op_stride  [MAX_OPS];
    logic [31:0]           op_idx     [MAX_OPS];  // Indexed lane addresses, one byte per lane
    logic [3:0]            op_mask    [MAX_OPS];
    vmem_pkg::word_t       op_wdata   [MAX_OPS][vmem_pkg::NUM_LANES];
    vmem_pkg::word_t       op_expect  [MAX_OPS][vmem_pkg::NUM_LANES];
    int                    num_ops;

    // Reference model state
    logic [7:0]            shadow [RAM_WORDS*4];
    vmem_pkg::word_t       model_lanes [vmem_pkg::NUM_LANES];
    vmem_pkg::word_t       model_run;
    integer                seed;

    vmem_unit #(
        .MEM_LATENCY (MEM_LATENCY),
        .RAM_WORDS   (RAM_WORDS),
        .UOP_BITS    (2)
    ) u_vmem_unit (
        .CLK              (CLK),
        .nRST             (nRST),
        .vmemren          (vmemren),
        .vmemwen          (vmemwen),
        .vindexed         (vindexed),
        .veew             (veew),
        .vuop_num         (vuop_num),
        .base             (base),
        .stride           (stride),
        .vlane_addr       (vlane_addr),
        .vlane_mask       (vlane_mask),
        .vlane_store_data (vlane_store_data),
        .vlane_load_data  (vlane_load_data),
        .stall            (stall)
    );

    bind vmem_serializer vmem_unit_sva u_sva (
        .CLK     (CLK),
        .nRST    (nRST),
        .vmemren (vmemren),
        .vmemwen (vmemwen),
        .ren     (lsc.ren),
        .wen     (lsc.wen),
        .ready   (lsc.ready),
        .stall   (stall),
        .addr    (lsc.addr),
        .mask    (vlane_mask)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task check_value(input string name, input vmem_pkg::word_t got, input vmem_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task report_timeout(input int n);
        $display("Timeout: stall did not fall within %0d cycles on micro-op %0d", WAIT_LIMIT, n);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    function automatic int elem_bytes(input vmem_pkg::sew_t eew);
        case (eew)
            vmem_pkg::SEW8:  return 1;
            vmem_pkg::SEW16: return 2;
            default:         return 4;
        endcase
    endfunction

    // Append one micro-op and predict its lane results from the shadow memory
    task add_op(input logic st, input logic idx, input vmem_pkg::sew_t eew, input logic [1:0] uop,
                input vmem_pkg::word_t b, input vmem_pkg::word_t s, input logic [31:0] lane_bytes,
                input logic [3:0] m);
        vmem_pkg::word_t start;
        vmem_pkg::word_t a;
        vmem_pkg::word_t val;
        int              nb;
        start = (uop == 2'd0) ? b : model_run;  // Later micro-ops continue the walk
        nb    = elem_bytes(eew);
        op_store[num_ops]   = st;
        op_indexed[num_ops] = idx;
        op_eew[num_ops]     = eew;
        op_uop[num_ops]     = uop;
        op_base[num_ops]    = b;
        op_stride[num_ops]  = s;
        op_idx[num_ops]     = lane_bytes;
        op_mask[num_ops]    = m;
        for (int l = 0; l < vmem_pkg::NUM_LANES; l++) begin
            op_wdata[num_ops][l] = $random(seed);
            a = idx ? {24'b0, lane_bytes[8*l +: 8]} : start + s * l;
            val = '0;
            if (m[l]) begin
                for (int k = 0; k < nb; k++) begin
                    if (st) begin
                        shadow[int'(a[9:0]) + k] = op_wdata[num_ops][l][8*k +: 8];
                    end else begin
                        val[8*k +: 8] = shadow[int'(a[9:0]) + k];
                    end
                end
                if (!st) begin
                    model_lanes[l] = val;  // Zero extended by construction
                end
            end
            op_expect[num_ops][l] = model_lanes[l];
        end
        model_run = start + s * 4;
        num_ops++;
    endtask

    task build_table;
        add_op(1, 0, vmem_pkg::SEW32, 0, 32'h40, 4, 0, 4'b1111);   // Unit-stride word store
        add_op(0, 0, vmem_pkg::SEW32, 0, 32'h40, 4, 0, 4'b1111);   // Read it back
        add_op(1, 0, vmem_pkg::SEW32, 0, 32'h80, 4, 0, 4'b1111);   // Fill 0x80 to 0xAF
        add_op(1, 0, vmem_pkg::SEW32, 1, 32'h80, 4, 0, 4'b1111);
        add_op(1, 0, vmem_pkg::SEW32, 2, 32'h80, 4, 0, 4'b1111);
        add_op(1, 0, vmem_pkg::SEW8,  0, 32'h80, 5, 0, 4'b1111);   // Stride 5 bytes over two micro-ops
        add_op(1, 0, vmem_pkg::SEW8,  1, 32'h80, 5, 0, 4'b1111);
        add_op(0, 0, vmem_pkg::SEW32, 0, 32'h80, 4, 0, 4'b1111);
        add_op(0, 0, vmem_pkg::SEW32, 1, 32'h80, 4, 0, 4'b1111);
        add_op(0, 0, vmem_pkg::SEW32, 2, 32'h80, 4, 0, 4'b1111);
        add_op(0, 0, vmem_pkg::SEW16, 0, 32'h42, 4, 0, 4'b1111);   // Halfwords at offset 2
        add_op(0, 0, vmem_pkg::SEW8,  0, 32'h81, 9, 0, 4'b1111);   // Byte offsets 1, 2, 3, 0
        add_op(0, 1, vmem_pkg::SEW32, 0, 32'h0, 0, 32'h4488404c, 4'b1111);
        add_op(1, 0, vmem_pkg::SEW32, 0, 32'h40, 4, 0, 4'b0101);   // Lanes 1 and 3 off
        add_op(0, 0, vmem_pkg::SEW32, 0, 32'h80, 4, 0, 4'b0101);
        add_op(0, 0, vmem_pkg::SEW32, 0, 32'h40, 4, 0, 4'b1111);
        add_op(1, 1, vmem_pkg::SEW16, 0, 32'h0, 0, 32'h9a4c8286, 4'b1011);
        add_op(0, 1, vmem_pkg::SEW16, 0, 32'h0, 0, 32'h868298a0, 4'b1111);
    endtask

    // Drive one entry on a falling edge, then wait for the micro-op to finish
    task run_op(input int n);
        int cycles;
        int active;
        vmemren    = ~op_store[n];
        vmemwen    = op_store[n];
        vindexed   = op_indexed[n];
        veew       = op_eew[n];
        vuop_num   = op_uop[n];
        base       = op_base[n];
        stride     = op_stride[n];
        vlane_mask = op_mask[n];
        for (int l = 0; l < vmem_pkg::NUM_LANES; l++) begin
            vlane_addr[l]       = {24'b0, op_idx[n][8*l +: 8]};
            vlane_store_data[l] = op_wdata[n][l];
        end
        active = $countones(op_mask[n]);
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout(n);
            end
        end while (stall);
        check_value("micro-op cycle count", vmem_pkg::word_t'(cycles + 1),
                    vmem_pkg::word_t'(active * MEM_LATENCY + 4 - active));
        @(negedge CLK);  // Last lane completes on the edge before this
        for (int l = 0; l < vmem_pkg::NUM_LANES; l++) begin
            check_value($sformatf("vlane_load_data[%0d]", l), vlane_load_data[l], op_expect[n][l]);
        end
    endtask

    initial begin
        seed       = 32'h56b2c51d;
        nRST       = 1'b0;
        vmemren    = 1'b0;
        vmemwen    = 1'b0;
        vindexed   = 1'b0;
        veew       = vmem_pkg::SEW32;
        vuop_num   = '0;
        base       = '0;
        stride     = '0;
        vlane_mask = '0;
        model_run  = '0;
        num_ops    = 0;
        for (int l = 0; l < vmem_pkg::NUM_LANES; l++) begin
            vlane_addr[l]       = '0;
            vlane_store_data[l] = '0;
            model_lanes[l]      = '0;
        end
        build_table();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        check_value("stall", vmem_pkg::word_t'(stall), 32'h0);
        for (int l = 0; l < vmem_pkg::NUM_LANES; l++) begin
            check_value($sformatf("vlane_load_data[%0d]", l), vlane_load_data[l], 32'h0);
        end
        for (int n = 0; n < num_ops; n++) begin
            run_op(n);
        end
        vmemren = 1'b0;
        vmemwen = 1'b0;
        @(negedge CLK);
        check_value("stall", vmem_pkg::word_t'(stall), 32'h0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
